// ==== flist.f ====
rtl/raster_csr_pkg.sv
rtl/raster_stamp_latch.sv
rtl/raster_csr_store.sv
rtl/raster_csr_wb_port.sv
rtl/raster_csr_top.sv
test/tb_raster_csr.sv

// ==== rtl/raster_csr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster CSR package
// Stamp and CSR word types shared by the raster CSR pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package raster_csr_pkg;

    // CSR data word, also the Wishbone data width
    typedef logic [31:0] csr_word_t;

    // Pixel coordinate
    typedef logic [13:0] dim_t;

    // Fragment coverage mask, one bit per sample
    typedef logic [3:0] cov_mask_t;

    // Number of CSR words held per thread
    localparam int RASTER_CSR_COUNT = 4;

    // One lane's fragment as delivered by the raster unit
    typedef struct packed {
        dim_t      pos_x;
        dim_t      pos_y;
        cov_mask_t mask;
        csr_word_t bcoord_x;
        csr_word_t bcoord_y;
        csr_word_t bcoord_z;
    } raster_stamp_t;

    // Stored words of one thread
    // pos_mask is {pos_y, pos_x, mask}
    typedef struct packed {
        csr_word_t pos_mask;
        csr_word_t bcoord_x;
        csr_word_t bcoord_y;
        csr_word_t bcoord_z;
    } raster_csrs_t;

    // CSR index within a thread, low address bits
    typedef enum logic [1:0] {
        CSR_POS_MASK = 2'd0,
        CSR_BCOORD_X = 2'd1,
        CSR_BCOORD_Y = 2'd2,
        CSR_BCOORD_Z = 2'd3
    } raster_csr_idx_e;

endpackage

// ==== rtl/raster_csr_store.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster CSR store
// Per-thread CSR words, one entry per warp
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module raster_csr_store #(
    parameter int  THREAD_CNT = 4,
    parameter int  WARP_CNT   = 4,
    localparam int WID_W      = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1,
    localparam int TID_W      = (THREAD_CNT > 1) ? $clog2(THREAD_CNT) : 1
) (
    input  logic                                          clk,

    // Write port from the stamp latch
    input  logic [THREAD_CNT-1:0]                         st_write,
    input  logic [WID_W-1:0]                              st_waddr,
    input  raster_csr_pkg::raster_csrs_t [THREAD_CNT-1:0] st_wdata,

    // Read port from the Wishbone side
    input  logic [WID_W-1:0]                              rd_wid,
    input  logic [TID_W-1:0]                              rd_tid,
    output raster_csr_pkg::raster_csrs_t                  rd_data
);

    raster_csr_pkg::raster_csrs_t [THREAD_CNT-1:0] thread_rdata;

    for (genvar t = 0; t < THREAD_CNT; t++) begin : g_thread
        // One warp-deep array per thread
        raster_csr_pkg::raster_csrs_t mem [WARP_CNT];

        always_ff @(posedge clk) begin
            if (st_write[t]) begin
                mem[st_waddr] <= st_wdata[t];
            end
        end

        // Every thread reads the same warp entry
        assign thread_rdata[t] = mem[rd_wid];
    end

    // Thread select after the warp lookup
    assign rd_data = thread_rdata[rd_tid];

    // Decoded thread index must name a real thread
    property p_rd_tid_range;
        @(posedge clk)
        !$isunknown(rd_tid) |-> (rd_tid < THREAD_CNT);
    endproperty

    a_rd_tid_range: assert property (p_rd_tid_range)
        else $error("rd_tid %0d beyond THREAD_CNT", rd_tid);

endmodule

// ==== rtl/raster_csr_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster CSR block top
// Stamp latch, CSR store and Wishbone read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module raster_csr_top #(
    parameter int  NUM_LANES  = 2,
    parameter int  THREAD_CNT = 4,
    parameter int  WARP_CNT   = 4,
    localparam int GROUP_CNT  = THREAD_CNT / NUM_LANES,
    localparam int WID_W      = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1,
    localparam int TID_W      = (THREAD_CNT > 1) ? $clog2(THREAD_CNT) : 1,
    localparam int PID_W      = (GROUP_CNT > 1) ? $clog2(GROUP_CNT) : 1
) (
    input  logic                                          clk,
    input  logic                                          rst,

    // Stamp input
    input  logic                                          write_enable,
    input  logic [WID_W-1:0]                              write_wid,
    input  logic [PID_W-1:0]                              write_pid,
    input  logic [NUM_LANES-1:0]                          write_tmask,
    input  raster_csr_pkg::raster_stamp_t [NUM_LANES-1:0] write_data,

    // Wishbone classic slave
    input  logic                                          wb_cyc,
    input  logic                                          wb_stb,
    input  logic                                          wb_we,
    input  logic [31:0]                                   wb_adr,
    input  raster_csr_pkg::csr_word_t                     wb_dat_w,
    input  logic [3:0]                                    wb_sel,
    output raster_csr_pkg::csr_word_t                     wb_dat_r,
    output logic                                          wb_ack
);

    // Latch to store
    logic [THREAD_CNT-1:0]                         st_write;
    logic [WID_W-1:0]                              st_waddr;
    raster_csr_pkg::raster_csrs_t [THREAD_CNT-1:0] st_wdata;

    // Wishbone port to store
    logic [WID_W-1:0]                              rd_wid;
    logic [TID_W-1:0]                              rd_tid;
    raster_csr_pkg::raster_csrs_t                  rd_data;

    raster_stamp_latch #(
        .NUM_LANES    (NUM_LANES),
        .THREAD_CNT   (THREAD_CNT),
        .WARP_CNT     (WARP_CNT)
    ) u_latch (
        .clk          (clk),
        .rst          (rst),
        .write_enable (write_enable),
        .write_wid    (write_wid),
        .write_pid    (write_pid),
        .write_tmask  (write_tmask),
        .write_data   (write_data),
        .st_write     (st_write),
        .st_waddr     (st_waddr),
        .st_wdata     (st_wdata)
    );

    raster_csr_store #(
        .THREAD_CNT   (THREAD_CNT),
        .WARP_CNT     (WARP_CNT)
    ) u_store (
        .clk          (clk),
        .st_write     (st_write),
        .st_waddr     (st_waddr),
        .st_wdata     (st_wdata),
        .rd_wid       (rd_wid),
        .rd_tid       (rd_tid),
        .rd_data      (rd_data)
    );

    raster_csr_wb_port #(
        .THREAD_CNT   (THREAD_CNT),
        .WARP_CNT     (WARP_CNT)
    ) u_wb (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .rd_wid       (rd_wid),
        .rd_tid       (rd_tid),
        .rd_data      (rd_data)
    );

endmodule

// ==== rtl/raster_csr_wb_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster CSR Wishbone port
// Classic slave, decodes and returns one CSR word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module raster_csr_wb_port #(
    parameter int  THREAD_CNT = 4,
    parameter int  WARP_CNT   = 4,
    localparam int IDX_W      = $clog2(raster_csr_pkg::RASTER_CSR_COUNT),
    localparam int WID_W      = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1,
    localparam int TID_W      = (THREAD_CNT > 1) ? $clog2(THREAD_CNT) : 1
) (
    input  logic                         clk,
    input  logic                         rst,

    // Wishbone classic slave
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [31:0]                  wb_adr,
    input  raster_csr_pkg::csr_word_t    wb_dat_w,
    input  logic [3:0]                   wb_sel,
    output raster_csr_pkg::csr_word_t    wb_dat_r,
    output logic                         wb_ack,

    // Store read port
    output logic [WID_W-1:0]             rd_wid,
    output logic [TID_W-1:0]             rd_tid,
    input  raster_csr_pkg::raster_csrs_t rd_data
);

    logic                            req;
    raster_csr_pkg::raster_csr_idx_e csr_idx;
    raster_csr_pkg::csr_word_t       rd_word;

    // New access only while no ack is pending
    assign req = wb_cyc && wb_stb && !wb_ack;

    // Word address layout, low to high: CSR index, thread, warp
    // Upper address bits are don't care
    assign csr_idx = raster_csr_pkg::raster_csr_idx_e'(wb_adr[IDX_W-1:0]);
    assign rd_tid  = wb_adr[IDX_W +: TID_W];
    assign rd_wid  = wb_adr[IDX_W + TID_W +: WID_W];

    // Word select within the thread's CSRs
    always_comb begin
        case (csr_idx)
            raster_csr_pkg::CSR_POS_MASK: rd_word = rd_data.pos_mask;
            raster_csr_pkg::CSR_BCOORD_X: rd_word = rd_data.bcoord_x;
            raster_csr_pkg::CSR_BCOORD_Y: rd_word = rd_data.bcoord_y;
            raster_csr_pkg::CSR_BCOORD_Z: rd_word = rd_data.bcoord_z;
            default:                      rd_word = rd_data.pos_mask;
        endcase
    end

    // Single-cycle ack, one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // CSRs are read-only, so wb_dat_w and wb_sel have no effect
    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            wb_dat_r <= rd_word;
        end
    end

    // Ack only answers a request seen on the previous edge
    property p_ack_has_req;
        @(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb);
    endproperty

    a_ack_has_req: assert property (p_ack_has_req)
        else $error("wb_ack raised without cyc and stb");

    // Exactly one ack cycle per access
    property p_ack_single;
        @(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack;
    endproperty

    a_ack_single: assert property (p_ack_single)
        else $error("wb_ack high for two cycles");

endmodule

// ==== rtl/raster_stamp_latch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster stamp latch
// Registers a stamp write as per-thread strobes and CSR words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module raster_stamp_latch #(
    parameter int  NUM_LANES  = 2,
    parameter int  THREAD_CNT = 4,
    parameter int  WARP_CNT   = 4,
    localparam int GROUP_CNT  = THREAD_CNT / NUM_LANES,
    localparam int WID_W      = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1,
    localparam int PID_W      = (GROUP_CNT > 1) ? $clog2(GROUP_CNT) : 1
) (
    input  logic                                          clk,
    input  logic                                          rst,

    // Stamp input from the raster unit
    input  logic                                          write_enable,
    input  logic [WID_W-1:0]                              write_wid,
    input  logic [PID_W-1:0]                              write_pid,
    input  logic [NUM_LANES-1:0]                          write_tmask,
    input  raster_csr_pkg::raster_stamp_t [NUM_LANES-1:0] write_data,

    // Registered write towards the store
    output logic [THREAD_CNT-1:0]                         st_write,
    output logic [WID_W-1:0]                              st_waddr,
    output raster_csr_pkg::raster_csrs_t [THREAD_CNT-1:0] st_wdata
);

    logic [THREAD_CNT-1:0]                         write_next;
    raster_csr_pkg::raster_csrs_t [THREAD_CNT-1:0] wdata_next;

    if (THREAD_CNT % NUM_LANES != 0) begin : g_bad_cfg
        $error("THREAD_CNT must be a multiple of NUM_LANES");
    end

    // Thread t is served by lane t % NUM_LANES of group t / NUM_LANES
    for (genvar t = 0; t < THREAD_CNT; t++) begin : g_thread
        localparam int LANE  = t % NUM_LANES;
        localparam int GROUP = t / NUM_LANES;

        raster_csr_pkg::raster_stamp_t stamp;

        assign stamp = write_data[LANE];

        assign write_next[t] = write_enable
                            && write_tmask[LANE]
                            && (write_pid == PID_W'(GROUP));

        // Position and coverage share one word
        assign wdata_next[t].pos_mask = {stamp.pos_y, stamp.pos_x, stamp.mask};
        assign wdata_next[t].bcoord_x = stamp.bcoord_x;
        assign wdata_next[t].bcoord_y = stamp.bcoord_y;
        assign wdata_next[t].bcoord_z = stamp.bcoord_z;
    end

    // Strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            st_write <= '0;
        end else begin
            st_write <= write_next;
        end
    end

    // Warp index and payload load only on a write
    always_ff @(posedge clk) begin
        if (write_enable) begin
            st_waddr <= write_wid;
            st_wdata <= wdata_next;
        end
    end

    // Group id must address an existing thread group
    property p_pid_in_range;
        @(posedge clk) disable iff (rst)
        write_enable |-> (write_pid < GROUP_CNT);
    endproperty

    a_pid_in_range: assert property (p_pid_in_range)
        else $error("write_pid %0d out of range", write_pid);

endmodule

// ==== test/tb_raster_csr.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster CSR block testbench
// Stamp writes, Wishbone reads and model checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_raster_csr;

    localparam int NUM_LANES   = 2;
    localparam int THREAD_CNT  = 4;
    localparam int WARP_CNT    = 4;
    localparam int GROUP_CNT   = THREAD_CNT / NUM_LANES;
    localparam int WID_W       = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1;
    localparam int TID_W       = (THREAD_CNT > 1) ? $clog2(THREAD_CNT) : 1;
    localparam int PID_W       = (GROUP_CNT > 1) ? $clog2(GROUP_CNT) : 1;
    localparam int IDX_W       = $clog2(raster_csr_pkg::RASTER_CSR_COUNT);
    localparam int ADR_LO_W    = IDX_W + TID_W + WID_W;
    localparam int ACK_TIMEOUT = 20;

    logic                                          clk;
    logic                                          rst;
    logic                                          write_enable;
    logic [WID_W-1:0]                              write_wid;
    logic [PID_W-1:0]                              write_pid;
    logic [NUM_LANES-1:0]                          write_tmask;
    raster_csr_pkg::raster_stamp_t [NUM_LANES-1:0] write_data;
    logic                                          wb_cyc;
    logic                                          wb_stb;
    logic                                          wb_we;
    logic [31:0]                                   wb_adr;
    raster_csr_pkg::csr_word_t                     wb_dat_w;
    logic [3:0]                                    wb_sel;
    raster_csr_pkg::csr_word_t                     wb_dat_r;
    logic                                          wb_ack;

    // Reference model, warp by thread by CSR index
    raster_csr_pkg::csr_word_t model [WARP_CNT][THREAD_CNT][raster_csr_pkg::RASTER_CSR_COUNT];

    // State of the access in flight
    logic                      req_seen;
    logic                      pending;
    logic                      cap_we;
    logic [31:0]               cap_adr;
    raster_csr_pkg::csr_word_t cap_exp;

    int check_errors;
    int timeouts;

    raster_csr_top #(
        .NUM_LANES    (NUM_LANES),
        .THREAD_CNT   (THREAD_CNT),
        .WARP_CNT     (WARP_CNT)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .write_enable (write_enable),
        .write_wid    (write_wid),
        .write_pid    (write_pid),
        .write_tmask  (write_tmask),
        .write_data   (write_data),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // No ack before the first request
    a_idle_ack: assert property (@(posedge clk) disable iff (rst) !req_seen |-> !wb_ack)
        else begin
            check_errors++;
            $display("ERROR: wb_ack expected 0x0 actual 0x%0h before any request",
                     $sampled(wb_ack));
        end

    // Ack exactly one cycle after the request
    a_ack_latency: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else begin
            check_errors++;
            $display("ERROR: wb_ack expected 0x1 actual 0x%0h one cycle after request",
                     $sampled(wb_ack));
        end

    a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            check_errors++;
            $display("ERROR: wb_ack expected 0x0 actual 0x%0h in a second ack cycle",
                     $sampled(wb_ack));
        end

    a_ack_pending: assert property (@(posedge clk) disable iff (rst) wb_ack |-> pending)
        else begin
            check_errors++;
            $display("Acknowledge seen with no Wishbone access outstanding");
        end

    // Read data against the model entry of the captured address
    a_rd_data: assert property (@(posedge clk) disable iff (rst)
        (wb_ack && !cap_we) |-> (wb_dat_r == cap_exp))
        else begin
            check_errors++;
            $display("ERROR: wb_dat_r expected 0x%08h actual 0x%08h at adr 0x%08h",
                     $sampled(cap_exp), $sampled(wb_dat_r), $sampled(cap_adr));
        end

    function automatic raster_csr_pkg::raster_stamp_t random_stamp();
        raster_csr_pkg::raster_stamp_t s;
        s.pos_x    = 14'($urandom());
        s.pos_y    = 14'($urandom());
        s.mask     = 4'($urandom());
        s.bcoord_x = $urandom();
        s.bcoord_y = $urandom();
        s.bcoord_z = $urandom();
        return s;
    endfunction

    // One-cycle stamp write, model follows the lane to thread mapping
    task automatic write_stamp(input int w, input int p, input logic [NUM_LANES-1:0] tmask);
        raster_csr_pkg::raster_stamp_t s;
        int                            t;
        write_enable = 1'b1;
        write_wid    = WID_W'(w);
        write_pid    = PID_W'(p);
        write_tmask  = tmask;
        for (int l = 0; l < NUM_LANES; l++) begin
            s = random_stamp();
            write_data[l] = s;
            if (tmask[l]) begin
                t = p * NUM_LANES + l;
                model[w][t][raster_csr_pkg::CSR_POS_MASK] = {s.pos_y, s.pos_x, s.mask};
                model[w][t][raster_csr_pkg::CSR_BCOORD_X] = s.bcoord_x;
                model[w][t][raster_csr_pkg::CSR_BCOORD_Y] = s.bcoord_y;
                model[w][t][raster_csr_pkg::CSR_BCOORD_Z] = s.bcoord_z;
            end
        end
        @(negedge clk);
        write_enable = 1'b0;
        write_tmask  = '0;
    endtask

    // Single Wishbone access, random upper address bits and sel
    task automatic wb_access(input logic we, input int w, input int t, input int i,
                             input raster_csr_pkg::csr_word_t data);
        logic [31:0] hi;
        int          cycles;
        hi       = $urandom();
        cap_adr  = {hi[31:ADR_LO_W], WID_W'(w), TID_W'(t), IDX_W'(i)};
        cap_we   = we;
        cap_exp  = model[w][t][i];
        pending  = 1'b1;
        req_seen = 1'b1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = cap_adr;
        wb_dat_w = data;
        wb_sel   = 4'($urandom());
        cycles   = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_ack && cycles < ACK_TIMEOUT);
        if (!wb_ack) begin
            timeouts++;
            $display("Timeout: no acknowledge within %0d cycles for address 0x%08h",
                     ACK_TIMEOUT, cap_adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // Idle gap before the next access
        @(negedge clk);
        pending = 1'b0;
    endtask

    task automatic read_all();
        // Let the last stamp reach the store
        @(negedge clk);
        for (int w = 0; w < WARP_CNT; w++) begin
            for (int t = 0; t < THREAD_CNT; t++) begin
                for (int i = 0; i < raster_csr_pkg::RASTER_CSR_COUNT; i++) begin
                    wb_access(1'b0, w, t, i, '0);
                end
            end
        end
    endtask

    initial begin
        int w;
        int p;
        int t;
        int i;
        void'($urandom(32'h6c42ddc1));
        rst          = 1'b1;
        write_enable = 1'b0;
        write_wid    = '0;
        write_pid    = '0;
        write_tmask  = '0;
        write_data   = '0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        wb_sel       = '0;
        req_seen     = 1'b0;
        pending      = 1'b0;
        cap_we       = 1'b0;
        cap_adr      = '0;
        cap_exp      = '0;
        check_errors = 0;
        timeouts     = 0;

        repeat (2) @(negedge clk);
        rst = 1'b0;

        // Idle bus after reset
        repeat (5) @(negedge clk);

        // Full-mask fill of every warp and group, back to back
        for (int k = 0; k < WARP_CNT * GROUP_CNT; k++) begin
            write_stamp(k / GROUP_CNT, k % GROUP_CNT, '1);
        end
        read_all();

        // Partial and empty lane masks
        write_stamp(1, 0, 2'b01);
        write_stamp(2, 1, 2'b10);
        write_stamp(3, 0, 2'b00);
        read_all();

        // One group of one warp, the rest must hold
        write_stamp(0, 1, '1);
        read_all();

        // Wishbone writes leave the CSRs untouched
        for (int k = 0; k < 6; k++) begin
            w = $urandom() % WARP_CNT;
            t = $urandom() % THREAD_CNT;
            i = $urandom() % raster_csr_pkg::RASTER_CSR_COUNT;
            wb_access(1'b1, w, t, i, $urandom());
            wb_access(1'b0, w, t, i, '0);
        end

        // Read sampled two cycles after the stamp write
        for (int k = 0; k < 8; k++) begin
            w = $urandom() % WARP_CNT;
            p = $urandom() % GROUP_CNT;
            t = p * NUM_LANES + ($urandom() % NUM_LANES);
            i = $urandom() % raster_csr_pkg::RASTER_CSR_COUNT;
            write_stamp(w, p, '1);
            @(negedge clk);
            wb_access(1'b0, w, t, i, '0);
        end

        repeat (3) @(negedge clk);
        $display("Run complete: %0d check errors, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
